/* source/bus_pkg.sv */
// --------------------------------------------------------------------------
// register bus definitions: APB request/response and address decoding views
// --------------------------------------------------------------------------

package bus_pkg;

    localparam int addr_w = 16;                 // register address width
    localparam int data_w = 32;                 // quadlet data width

    // region view, top nibble picks the space
    typedef struct packed {
        logic [3:0]  region;
        logic [11:0] rest;
    } rgn_view_t;

    // channel view, used by main space and hub
    typedef struct packed {
        logic [3:0] region;
        logic [3:0] unused;                     // reserved, ignored by decode
        logic [3:0] chan;                       // 0 = board regs, 1..n = axes
        logic [3:0] offset;                     // register within channel
    } chan_view_t;

    typedef union packed {
        rgn_view_t  rgn;
        chan_view_t ch;
    } reg_addr_u;

    localparam logic [3:0] region_main = 4'd0;  // board + axis channels
    localparam logic [3:0] region_hub  = 4'd1;  // 16-word hub memory

    // requester side of one transfer, 51 bits
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        reg_addr_u         paddr;
        logic [data_w-1:0] pwdata;
    } apb_req_t;

    // completer side, 34 bits
    typedef struct packed {
        logic [data_w-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage

/* source/board_pkg.sv */
// --------------------------------------------------------------------------
// board level constants: current type, status layout, channel offsets
// --------------------------------------------------------------------------

package board_pkg;

    typedef logic signed [15:0] cur_t;              // motor current, signed

    // per-axis channel registers
    localparam logic [3:0] off_cmd         = 4'd0;  // current command
    localparam logic [3:0] off_fb          = 4'd1;  // feedback readback
    localparam logic [3:0] off_axis_status = 4'd2;  // safety status

    // channel 0 (board) registers
    localparam logic [3:0] off_board_status = 4'd0;
    localparam logic [3:0] off_amp_enable   = 4'd1;

    // board status quadlet
    typedef struct packed {
        logic [3:0]  board_id;                      // 31..28
        logic [15:0] rsvd_hi;                       // 27..12, zero
        logic [3:0]  amp_en;                        // 11..8, live enables
        logic [3:0]  rsvd_lo;                       // 7..4, zero
        logic [3:0]  amp_dis;                       // 3..0, safety trips
    } board_status_t;

endpackage

/* source/hub_mem.sv */
// --------------------------------------------------------------------------
// hub register memory, 16 quadlets shared by both hosts
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module hub_mem (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic                        wr_en,
    input  logic [3:0]                  offset,     // word index
    input  logic [bus_pkg::data_w-1:0]  wdata,
    output logic [bus_pkg::data_w-1:0]  rdata
);

    logic [bus_pkg::data_w-1:0] mem [16];

    // cleared at reset, hub contents start known
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[offset] <= wdata;
        end
    end

    assign rdata = mem[offset];     // async read, same-cycle answer

endmodule

/* source/axis_channel.sv */
// --------------------------------------------------------------------------
// one axis: current command register, feedback readback, safety monitor
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module axis_channel #(
    parameter int safety_margin = 64,
    parameter int safety_hold   = 8
) (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic                        wr_en,
    input  logic [3:0]                  offset,
    input  logic [bus_pkg::data_w-1:0]  wdata,
    output logic [bus_pkg::data_w-1:0]  rdata,
    input  board_pkg::cur_t             cur_fb,
    output board_pkg::cur_t             cur_cmd,
    output logic                        amp_disable
);
    import board_pkg::*;

    localparam int cnt_w = $clog2(safety_hold + 1);

    cur_t               cmd_q;
    logic               wr_cmd;
    logic [16:0]        fb_mag, cmd_mag;    // 17 bits, |-32768| fits
    logic [18:0]        limit;              // 2*|cmd| + margin
    logic               over;
    logic [cnt_w-1:0]   run_cnt;            // consecutive over-limit cycles

    function automatic logic [16:0] mag(input cur_t v);
        logic signed [16:0] ext;
        ext = v;                            // sign extend
        return ext[16] ? 17'(-ext) : 17'(ext);
    endfunction

    assign wr_cmd  = wr_en && (offset == off_cmd);
    assign cur_cmd = cmd_q;
    assign fb_mag  = mag(cur_fb);
    assign cmd_mag = mag(cmd_q);
    assign limit   = {1'b0, cmd_mag, 1'b0} + 19'(safety_margin);
    assign over    = 19'(fb_mag) > limit;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q       <= '0;
            run_cnt     <= '0;
            amp_disable <= 1'b0;
        end else if (wr_cmd) begin              // new command re-arms monitor
            cmd_q       <= wdata[15:0];
            run_cnt     <= '0;
            amp_disable <= 1'b0;
        end else if (!over) begin
            run_cnt <= '0;                      // streak broken
        end else if (run_cnt == cnt_w'(safety_hold - 1)) begin
            amp_disable <= 1'b1;                // latched until next command
        end else begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    always_comb begin
        case (offset)
            off_cmd:         rdata = 32'(cmd_q);    // signed, so sign extended
            off_fb:          rdata = 32'(cur_fb);
            off_axis_status: rdata = {31'b0, amp_disable};
            default:         rdata = '0;
        endcase
    end

endmodule

/* source/board_regs.sv */
// --------------------------------------------------------------------------
// channel 0 board registers: status quadlet and amplifier enable mask
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module board_regs #(
    parameter int num_chan = 4
) (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic [3:0]                  board_id,       // rotary switch value
    input  logic                        wr_en,
    input  logic [3:0]                  offset,
    input  logic [bus_pkg::data_w-1:0]  wdata,
    output logic [bus_pkg::data_w-1:0]  rdata,
    input  logic [num_chan-1:0]         amp_disable,    // from safety monitors
    output logic [num_chan-1:0]         amp_enable
);
    import board_pkg::*;

    logic [num_chan-1:0]    mask_q;     // host requested enables
    board_status_t          status;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            mask_q <= '0;                               // amps off at reset
        end else if (wr_en && offset == off_amp_enable) begin
            mask_q <= wdata[num_chan-1:0];
        end
    end

    // a tripped axis stays off whatever the host asks
    assign amp_enable = mask_q & ~amp_disable;

    always_comb begin
        status          = '0;
        status.board_id = board_id;
        status.amp_en   = 4'(amp_enable);               // live mirror
        status.amp_dis  = 4'(amp_disable);
    end

    // ----------------------------------------------------------------------
    // read back
    // ----------------------------------------------------------------------
    always_comb begin
        case (offset)
            off_board_status: rdata = status;
            off_amp_enable:   rdata = 32'(mask_q);
            default:          rdata = '0;
        endcase
    end

endmodule

/* source/reg_decoder.sv */
// --------------------------------------------------------------------------
// register address decode: write strobes, read data mux, error on unmapped
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module reg_decoder #(
    parameter int num_chan = 4
) (
    input  logic                                    sysclk,
    input  logic                                    arst_n,
    input  bus_pkg::apb_req_t                       bus_req,
    output bus_pkg::apb_rsp_t                       bus_rsp,
    output logic                                    wr_en_board,
    output logic [num_chan-1:0]                     wr_en_axis,
    output logic                                    wr_en_hub,
    output logic [3:0]                              offset,
    output logic [bus_pkg::data_w-1:0]              wdata,
    input  logic [bus_pkg::data_w-1:0]              rdata_board,
    input  logic [num_chan-1:0][bus_pkg::data_w-1:0] rdata_axis,
    input  logic [bus_pkg::data_w-1:0]              rdata_hub
);
    import bus_pkg::*;

    reg_addr_u          addr;
    logic               is_main, is_hub, chan_ok, mapped;
    logic [3:0]         chan;
    logic [3:0]         chan_idx;       // axis array index, chan - 1
    logic               wr;             // write in access phase
    logic               ready_q;
    logic [data_w-1:0]  rdata_mux;

    assign addr     = bus_req.paddr;
    assign is_main  = (addr.rgn.region == region_main);     // region view
    assign is_hub   = (addr.rgn.region == region_hub);
    assign chan     = addr.ch.chan;                         // channel view
    assign chan_idx = chan - 4'd1;
    assign chan_ok  = (chan <= 4'(num_chan));
    assign mapped   = is_hub || (is_main && chan_ok);
    assign offset   = addr.ch.offset;   // hub word index too
    assign wdata    = bus_req.pwdata;

    assign wr          = bus_req.psel && bus_req.penable && bus_req.pwrite;
    assign wr_en_board = wr && is_main && (chan == 4'd0);
    assign wr_en_hub   = wr && is_hub;

    always_comb begin
        for (int i = 0; i < num_chan; i++) begin
            wr_en_axis[i] = wr && is_main && (chan == 4'(i + 1));
        end
    end

    // setup seen -> ready in the access cycle, zero wait states
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) ready_q <= 1'b0;
        else         ready_q <= bus_req.psel && !bus_req.penable;
    end

    always_comb begin
        rdata_mux = '0;                                     // unmapped reads 0
        if (is_hub)                          rdata_mux = rdata_hub;
        else if (is_main && chan == 4'd0)    rdata_mux = rdata_board;
        else if (is_main && chan_ok)         rdata_mux = rdata_axis[chan_idx];
    end

    assign bus_rsp.prdata  = rdata_mux;
    assign bus_rsp.pready  = ready_q;
    assign bus_rsp.pslverr = !mapped;   // sampled with pready only

endmodule

/* source/host_arbiter.sv */
// --------------------------------------------------------------------------
// two-host APB arbiter, alternates grants and forwards one transfer at a time
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module host_arbiter (
    input  logic                sysclk,
    input  logic                arst_n,
    input  bus_pkg::apb_req_t   fw_req,
    output bus_pkg::apb_rsp_t   fw_rsp,
    input  bus_pkg::apb_req_t   eth_req,
    output bus_pkg::apb_rsp_t   eth_rsp,
    output bus_pkg::apb_req_t   bus_req,
    input  bus_pkg::apb_rsp_t   bus_rsp
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_access
    } state_t;

    state_t     state;
    logic       last_eth;           // 1: ethernet host granted last / now
    logic       pick_eth;
    apb_req_t   req_q;              // captured request of granted host

    // fairness: on a tie the host not served last goes first
    assign pick_eth = eth_req.psel && (!fw_req.psel || !last_eth);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            last_eth <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (fw_req.psel || eth_req.psel) begin
                        state    <= st_setup;
                        last_eth <= pick_eth;   // doubles as current grant
                    end
                end
                st_setup:  state <= st_access;
                st_access: if (bus_rsp.pready) state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    // payload only, qualified by psel
    always_ff @(posedge sysclk) begin
        if (state == st_idle) req_q <= pick_eth ? eth_req : fw_req;
    end

    // replay the granted transfer toward the fabric
    always_comb begin
        bus_req         = req_q;
        bus_req.psel    = (state != st_idle);
        bus_req.penable = (state == st_access);
    end

    // response goes to the granted host only, the other keeps waiting
    always_comb begin
        fw_rsp  = '0;
        eth_rsp = '0;
        if (state == st_access) begin
            if (last_eth) eth_rsp = bus_rsp;
            else          fw_rsp  = bus_rsp;
        end
    end

endmodule

/* source/qla_board_top.sv */
// --------------------------------------------------------------------------
// motor controller register core: two hosts share board, axis and hub space
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module qla_board_top #(
    parameter int num_chan      = 4,            // number of axes
    parameter int safety_margin = 64,           // current units above 2x cmd
    parameter int safety_hold   = 8             // cycles over limit to trip
) (
    input  logic                                sysclk,
    input  logic                                arst_n,
    input  logic [3:0]                          board_id,
    input  bus_pkg::apb_req_t                   fw_req,     // firewire side host
    output bus_pkg::apb_rsp_t                   fw_rsp,
    input  bus_pkg::apb_req_t                   eth_req,    // ethernet side host
    output bus_pkg::apb_rsp_t                   eth_rsp,
    input  board_pkg::cur_t [num_chan-1:0]      cur_fb,
    output board_pkg::cur_t [num_chan-1:0]      cur_cmd,
    output logic [num_chan-1:0]                 amp_enable
);
    import bus_pkg::*;

    apb_req_t                           bus_req;        // arbitrated transfer
    apb_rsp_t                           bus_rsp;
    logic                               wr_en_board;
    logic [num_chan-1:0]                wr_en_axis;
    logic                               wr_en_hub;
    logic [3:0]                         offset;
    logic [data_w-1:0]                  wdata;
    logic [data_w-1:0]                  rdata_board;
    logic [num_chan-1:0][data_w-1:0]    rdata_axis;
    logic [data_w-1:0]                  rdata_hub;
    logic [num_chan-1:0]                amp_disable;    // safety trips per axis

    // ----------------------------------------------------------------------
    // host side and register fabric
    // ----------------------------------------------------------------------
    host_arbiter i_host_arbiter (
        .sysclk, .arst_n,
        .fw_req, .fw_rsp, .eth_req, .eth_rsp,
        .bus_req, .bus_rsp
    );

    reg_decoder #(.num_chan(num_chan)) i_reg_decoder (
        .sysclk, .arst_n, .bus_req, .bus_rsp,
        .wr_en_board, .wr_en_axis, .wr_en_hub, .offset, .wdata,
        .rdata_board, .rdata_axis, .rdata_hub
    );

    // ----------------------------------------------------------------------
    // register targets
    // ----------------------------------------------------------------------
    board_regs #(.num_chan(num_chan)) i_board_regs (
        .sysclk, .arst_n, .board_id,
        .wr_en(wr_en_board), .offset, .wdata, .rdata(rdata_board),
        .amp_disable, .amp_enable
    );

    for (genvar i = 0; i < num_chan; i++) begin : g_axis   // channel i+1
        axis_channel #(
            .safety_margin(safety_margin),
            .safety_hold(safety_hold)
        ) i_axis_channel (
            .sysclk, .arst_n,
            .wr_en(wr_en_axis[i]), .offset, .wdata, .rdata(rdata_axis[i]),
            .cur_fb(cur_fb[i]), .cur_cmd(cur_cmd[i]), .amp_disable(amp_disable[i])
        );
    end

    hub_mem i_hub_mem (
        .sysclk, .arst_n,
        .wr_en(wr_en_hub), .offset, .wdata, .rdata(rdata_hub)
    );

endmodule

/* sim/qla_board_chk.sv */
// --------------------------------------------------------------------------
// APB protocol assertions on both host ports of the register core
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module qla_board_chk (
    input logic                 sysclk,
    input logic                 arst_n,
    input bus_pkg::apb_req_t    fw_req,
    input bus_pkg::apb_rsp_t    fw_rsp,
    input bus_pkg::apb_req_t    eth_req,
    input bus_pkg::apb_rsp_t    eth_rsp
);

    // ----------------------------------------------------------------------
    // firewire side host
    // ----------------------------------------------------------------------
    a_fw_hold: assert property (@(posedge sysclk) disable iff (!arst_n)
        fw_req.psel && !fw_rsp.pready |=> fw_req.psel && $stable(fw_req.paddr))
        else $error("fw host released psel or moved paddr before pready");
    a_fw_enable: assert property (@(posedge sysclk) disable iff (!arst_n)
        fw_req.psel && !fw_req.penable |=> fw_req.penable)
        else $error("fw host penable did not follow psel");
    a_fw_ready: assert property (@(posedge sysclk) disable iff (!arst_n)
        fw_rsp.pready |-> fw_req.psel)
        else $error("fw port pready without psel");

    // ----------------------------------------------------------------------
    // ethernet side host
    // ----------------------------------------------------------------------
    a_eth_hold: assert property (@(posedge sysclk) disable iff (!arst_n)
        eth_req.psel && !eth_rsp.pready |=> eth_req.psel && $stable(eth_req.paddr))
        else $error("eth host released psel or moved paddr before pready");
    a_eth_enable: assert property (@(posedge sysclk) disable iff (!arst_n)
        eth_req.psel && !eth_req.penable |=> eth_req.penable)
        else $error("eth host penable did not follow psel");
    a_eth_ready: assert property (@(posedge sysclk) disable iff (!arst_n)
        eth_rsp.pready |-> eth_req.psel)
        else $error("eth port pready without psel");

endmodule

bind qla_board_top qla_board_chk i_qla_board_chk (
    .sysclk, .arst_n, .fw_req, .fw_rsp, .eth_req, .eth_rsp
);

/* sim/qla_board_tb.sv */
// --------------------------------------------------------------------------
// testbench for the register core with two random APB hosts against a model
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module qla_board_tb;
    import bus_pkg::*;
    import board_pkg::*;

    localparam int num_chan   = 4;
    localparam int margin     = 64;
    localparam int hold       = 8;
    localparam int n_hub      = 40;     // hub ops per host
    localparam int n_cmd      = 2;      // command values per axis
    localparam int n_bad      = 4;      // unmapped rounds of 4 transfers
    localparam int n_mask     = 3;
    localparam int total_xfer = 2 * n_hub + 16 + 2 * n_cmd * num_chan + 4 * n_bad
                              + 3 * n_mask + 7 * num_chan;

    logic sysclk = 1'b0;
    logic arst_n;
    logic [3:0] board_id;
    apb_req_t fw_req, eth_req;
    apb_rsp_t fw_rsp, eth_rsp;
    cur_t [num_chan-1:0] cur_fb, cur_cmd;
    logic [num_chan-1:0] amp_enable;

    integer seed = 14;
    int err_cnt = 0;
    int check_cnt = 0;
    logic [data_w-1:0] hub_m [16];      // reference model
    cur_t cmd_m [num_chan];
    logic [num_chan-1:0] mask_m, dis_m;
    logic op_wr [2][n_hub];             // pre-drawn hub stimulus
    logic [2:0] op_idx [2][n_hub];
    logic [data_w-1:0] op_data [2][n_hub];
    int done [2];                       // pready pulses seen per port

    qla_board_top #(.num_chan(num_chan), .safety_margin(margin), .safety_hold(hold))
        i_qla_board_top (.*);

    initial forever #2 sysclk = ~sysclk;    // 4 ns

    // ----------------------------------------------------------------------
    // compare tasks, address helpers, model rules
    // ----------------------------------------------------------------------
    task automatic check_rdata(input logic [data_w-1:0] got, exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_err(input logic got, exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s, pslverr %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_cur(input cur_t got, exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    function automatic logic [addr_w-1:0] make_addr(input logic [3:0] rgn, chan, off);
        return {rgn, 4'h0, chan, off};      // channel view of the address
    endfunction

    function automatic int abs_cur(input cur_t v);
        return (v < 0) ? -int'(v) : int'(v);
    endfunction

    function automatic logic over_limit(input cur_t fb, cmd);
        return abs_cur(fb) > 2 * abs_cur(cmd) + margin;
    endfunction

    function automatic logic [data_w-1:0] status_exp();
        return {board_id, 16'h0, mask_m & ~dis_m, 4'h0, dis_m};   // id, live en, trips
    endfunction

    function automatic apb_req_t setup_phase(input logic wr, input logic [addr_w-1:0] addr,
                                             input logic [data_w-1:0] wd);
        apb_req_t r;
        r = '0;
        r.psel   = 1'b1;
        r.pwrite = wr;
        r.paddr  = addr;
        r.pwdata = wd;
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // host ports with one APB transfer per call
    // ----------------------------------------------------------------------
    task automatic fw_access(input logic wr, input logic [addr_w-1:0] addr,
                             input logic [data_w-1:0] wd,
                             output logic [data_w-1:0] rd, output logic err);
        @(posedge sysclk);
        #1 fw_req = setup_phase(wr, addr, wd);
        @(posedge sysclk);
        #1 fw_req.penable = 1'b1;
        @(negedge sysclk);
        while (!fw_rsp.pready) @(negedge sysclk);  // arbiter back-pressure
        rd  = fw_rsp.prdata;
        err = fw_rsp.pslverr;
        @(posedge sysclk);
        #1 fw_req = '0;
    endtask

    task automatic eth_access(input logic wr, input logic [addr_w-1:0] addr,
                              input logic [data_w-1:0] wd,
                              output logic [data_w-1:0] rd, output logic err);
        @(posedge sysclk);
        #1 eth_req = setup_phase(wr, addr, wd);
        @(posedge sysclk);
        #1 eth_req.penable = 1'b1;
        @(negedge sysclk);
        while (!eth_rsp.pready) @(negedge sysclk);
        rd  = eth_rsp.prdata;
        err = eth_rsp.pslverr;
        @(posedge sysclk);
        #1 eth_req = '0;
    endtask

    // fw owns even hub words, eth odd ones, so the model stays exact
    task automatic hub_traffic(input int h);
        logic [data_w-1:0] rd;
        logic err;
        logic [3:0] word;
        for (int i = 0; i < n_hub; i++) begin
            word = {op_idx[h][i], h[0]};
            if (h == 0) begin
                fw_access(op_wr[h][i], make_addr(4'd1, 4'd0, word), op_data[h][i],
                          rd, err);
            end else begin
                eth_access(op_wr[h][i], make_addr(4'd1, 4'd0, word), op_data[h][i],
                           rd, err);
            end
            check_err(err, 1'b0, "hub access flag");
            if (op_wr[h][i]) hub_m[word] = op_data[h][i];
            else             check_rdata(rd, hub_m[word], "hub read word");
        end
    endtask

    task automatic set_fb(input int ax, input cur_t v);
        @(posedge sysclk);
        #1 cur_fb[ax] = v;
    endtask

    task automatic report_test(input int n, input string name, input int base);
        $display("[%0t ns] test %0d %s finished, %0d errors", $time, n, name, err_cnt - base);
    endtask

    // pready is stable at the falling edge, one pulse per completed transfer
    initial begin
        forever begin
            @(negedge sysclk);
            if (fw_rsp.pready)  done[0]++;
            if (eth_rsp.pready) done[1]++;
        end
    end

    // watchdog at 20 cycles per transfer
    initial begin
        repeat (total_xfer * 20) @(posedge sysclk);
        $display("timeout: run did not finish within %0d cycles", total_xfer * 20);
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [data_w-1:0] rd;
        logic err;
        int base;
        cur_t v, cmd;
        logic [3:0] rgn, chan;
        int m;
        arst_n   = 1'b0;
        fw_req   = '0;
        eth_req  = '0;
        cur_fb   = '0;
        board_id = 4'($random(seed));
        mask_m   = '0;
        dis_m    = '0;
        done     = '{0, 0};
        for (int i = 0; i < 16; i++) hub_m[i] = '0;
        for (int h = 0; h < 2; h++) begin
            for (int i = 0; i < n_hub; i++) begin
                op_wr[h][i]   = $random(seed);
                op_idx[h][i]  = $random(seed);
                op_data[h][i] = $random(seed);
            end
        end
        repeat (5) @(posedge sysclk);
        #1 arst_n = 1'b1;

        // test 1 has both hosts hammer the hub at once then read it all back
        base = err_cnt;
        fork
            hub_traffic(0);
            hub_traffic(1);
        join
        if (done[0] != n_hub || done[1] != n_hub) begin
            err_cnt++;
            $display("wrong number of pready pulses: fw %0d, eth %0d, expected %0d each",
                     done[0], done[1], n_hub);
        end
        for (int w = 0; w < 16; w++) begin
            fw_access(1'b0, make_addr(4'd1, 4'd0, 4'(w)), '0, rd, err);
            check_rdata(rd, hub_m[w], "hub readback");
        end
        report_test(1, "hub traffic", base);

        // test 2 commands sign extended on read and seen on cur_cmd
        base = err_cnt;
        for (int a = 0; a < num_chan; a++) begin
            for (int k = 0; k < n_cmd; k++) begin
                v = cur_t'($random(seed));
                fw_access(1'b1, make_addr(4'd0, 4'(a + 1), off_cmd), 32'(v), rd, err);
                cmd_m[a] = v;
                eth_access(1'b0, make_addr(4'd0, 4'(a + 1), off_cmd), '0, rd, err);
                check_rdata(rd, {{16{v[15]}}, v}, "command readback");
                check_err(err, 1'b0, "command read flag");
                check_cur(cur_cmd[a], cmd_m[a], "cur_cmd output");
            end
        end
        report_test(2, "axis commands", base);

        // test 3 unmapped regions and channels past the last axis
        base = err_cnt;
        for (int k = 0; k < n_bad; k++) begin
            rgn  = 4'd2 + 4'($unsigned($random(seed)) % 14);
            chan = 4'(num_chan + 1 + $unsigned($random(seed)) % (15 - num_chan));
            fw_access(1'b0, make_addr(rgn, 4'd0, 4'd0), '0, rd, err);
            check_rdata(rd, '0, "unmapped region read");
            check_err(err, 1'b1, "unmapped region read flag");
            eth_access(1'b1, make_addr(rgn, 4'd1, 4'd2), $random(seed), rd, err);
            check_err(err, 1'b1, "unmapped region write flag");
            eth_access(1'b0, make_addr(4'd0, chan, off_cmd), '0, rd, err);
            check_rdata(rd, '0, "bad channel read");
            check_err(err, 1'b1, "bad channel read flag");
            fw_access(1'b1, make_addr(4'd0, chan, off_cmd), $random(seed), rd, err);
            check_err(err, 1'b1, "bad channel write flag");
        end
        report_test(3, "unmapped space", base);

        // test 4 board status and enable mask with no faults yet
        base = err_cnt;
        for (int k = 0; k < n_mask; k++) begin
            mask_m = 4'($random(seed));
            eth_access(1'b1, make_addr(4'd0, 4'd0, off_amp_enable), 32'(mask_m), rd, err);
            fw_access(1'b0, make_addr(4'd0, 4'd0, off_amp_enable), '0, rd, err);
            check_rdata(rd, 32'(mask_m), "enable mask readback");
            fw_access(1'b0, make_addr(4'd0, 4'd0, off_board_status), '0, rd, err);
            check_rdata(rd, status_exp(), "board status");
            check_rdata(32'(amp_enable), 32'(mask_m), "amp_enable pins");
        end
        report_test(4, "board registers", base);

        // test 5 safety trip per axis, clear by command, boundary holds off
        base = err_cnt;
        for (int a = 0; a < num_chan; a++) begin
            cmd = cur_t'($random(seed) % 1000);
            fw_access(1'b1, make_addr(4'd0, 4'(a + 1), off_cmd), 32'(cmd), rd, err);
            cmd_m[a] = cmd;
            mask_m = '1;
            fw_access(1'b1, make_addr(4'd0, 4'd0, off_amp_enable), 32'(mask_m), rd, err);
            m = 2 * abs_cur(cmd) + margin + 1 + $unsigned($random(seed)) % 50;
            v = ($random(seed) & 1) ? cur_t'(-m) : cur_t'(m);
            set_fb(a, v);
            repeat (hold + 2) @(posedge sysclk);    // past the hold window
            if (over_limit(v, cmd_m[a])) dis_m[a] = 1'b1;
            eth_access(1'b0, make_addr(4'd0, 4'(a + 1), off_axis_status), '0, rd, err);
            check_rdata(rd, 32'(dis_m[a]), "axis status after overcurrent");
            eth_access(1'b0, make_addr(4'd0, 4'd0, off_board_status), '0, rd, err);
            check_rdata(rd, status_exp(), "board status with trip");
            check_rdata(32'(amp_enable), 32'(mask_m & ~dis_m), "amp_enable with trip");
            set_fb(a, '0);
            fw_access(1'b1, make_addr(4'd0, 4'(a + 1), off_cmd), 32'(cmd), rd, err);
            dis_m[a] = 1'b0;                        // new command re-arms
            eth_access(1'b0, make_addr(4'd0, 4'(a + 1), off_axis_status), '0, rd, err);
            check_rdata(rd, 32'(dis_m[a]), "axis status after clear");
            check_rdata(32'(amp_enable), 32'(mask_m & ~dis_m), "amp_enable after clear");
            v = cur_t'(2 * abs_cur(cmd) + margin);  // right at the limit
            set_fb(a, v);
            repeat (3 * hold) @(posedge sysclk);
            if (over_limit(v, cmd_m[a])) dis_m[a] = 1'b1;
            eth_access(1'b0, make_addr(4'd0, 4'(a + 1), off_axis_status), '0, rd, err);
            check_rdata(rd, 32'(dis_m[a]), "axis status at limit");
            set_fb(a, '0);
        end
        report_test(5, "safety monitor", base);

        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* compile.f */
source/bus_pkg.sv
source/board_pkg.sv
source/hub_mem.sv
source/axis_channel.sv
source/board_regs.sv
source/reg_decoder.sv
source/host_arbiter.sv
source/qla_board_top.sv
sim/qla_board_chk.sv
sim/qla_board_tb.sv

/* Bender.yml */
package:
  name: qla_board
  authors: []

dependencies: {}

sources:
  # packages first, then leaf blocks, then the top level
  - source/bus_pkg.sv
  - source/board_pkg.sv
  - source/hub_mem.sv
  - source/axis_channel.sv
  - source/board_regs.sv
  - source/reg_decoder.sv
  - source/host_arbiter.sv
  - source/qla_board_top.sv
  - target: simulation
    files:
      - sim/qla_board_chk.sv
      - sim/qla_board_tb.sv
